// ==== Bender.yml ====
package:
  name: ap_fetch

sources:
  - source/ap_isa_pkg.sv
  - source/ap_mem_pkg.sv
  - source/program_counter.sv
  - source/ins_cache.sv
  - source/isa_burst_reader.sv
  - source/ap_fetch_top.sv
  - target: test
    files:
      - bench/ddr_model.sv
      - bench/ap_fetch_tb.sv

// ==== ap_fetch.f ====
source/ap_isa_pkg.sv
source/ap_mem_pkg.sv
source/program_counter.sv
source/ins_cache.sv
source/isa_burst_reader.sv
source/ap_fetch_top.sv
bench/ddr_model.sv
bench/ap_fetch_tb.sv

// ==== bench/ap_fetch_tb.sv ====
module ap_fetch_tb
    import ap_isa_pkg::*;
    import ap_mem_pkg::*;
();

    localparam int DRIVE_DLY    = 1;
    localparam int RAND_SEED    = 52;
    localparam int HALT_TIMEOUT = 2000;
    localparam int QUIET_CYCLES = 50;
    localparam int WORD_BYTES   = 8;

    logic      clk;
    logic      rst;
    logic      ddr_rd_valid;
    ins_word_t ddr_rd_data;
    logic      ddr_rd_en;
    ddr_addr_t ddr_rd_addr;
    ins_word_t ins_word;
    logic      ins_valid;
    logic      halted;
    load_cnt_t load_times;
    logic      isa_read_req;

    ins_word_t prog [PROGRAM_WORDS];
    opcode_t   ins_op;
    ins_word_t exp_word;

    // Bookkeeping for the checks.
    logic      rst_check;
    int        ins_idx;
    int        rd_count;
    logic      rd_seen;
    ddr_addr_t prev_rd_addr;
    int        gap;
    logic      quiet;
    logic      have_prev;
    int        gap_checks;

    int err_reset = 0;
    int err_order = 0;
    int err_addr  = 0;
    int err_gap   = 0;
    int err_loads = 0;
    int err_halt  = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    ap_fetch_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .ddr_rd_valid (ddr_rd_valid),
        .ddr_rd_data  (ddr_rd_data),
        .ddr_rd_en    (ddr_rd_en),
        .ddr_rd_addr  (ddr_rd_addr),
        .ins_word     (ins_word),
        .ins_valid    (ins_valid),
        .halted       (halted),
        .load_times   (load_times),
        .isa_read_req (isa_read_req)
    );

    ddr_model ddr_mem (
        .clk      (clk),
        .rd_en    (ddr_rd_en),
        .rd_addr  (ddr_rd_addr),
        .image    (prog),
        .rd_valid (ddr_rd_valid),
        .rd_data  (ddr_rd_data)
    );

    assign ins_op   = ins_word.opcode;
    assign exp_word = (ins_idx < PROGRAM_WORDS) ? prog[ins_idx] : '0;

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #10 clk = ~clk;
        end
    end

    // Delivered instructions in order.
    always @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            ins_idx <= 0;
        end
        else if (ins_valid)
        begin
            ins_idx <= ins_idx + 1;
        end
    end

    // Last read address inside the current fill.
    always @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            rd_count     <= 0;
            rd_seen      <= 1'b0;
            prev_rd_addr <= '0;
        end
        else if (!isa_read_req)
        begin
            rd_seen <= 1'b0;
        end
        else if (ddr_rd_en)
        begin
            rd_count     <= rd_count + 1;
            rd_seen      <= 1'b1;
            prev_rd_addr <= ddr_rd_addr;
        end
    end

    // Cycles since the previous delivery, and whether a fill came in between.
    always @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            gap        <= 0;
            quiet      <= 1'b0;
            have_prev  <= 1'b0;
            gap_checks <= 0;
        end
        else if (ins_valid)
        begin
            if (have_prev && quiet)
            begin
                gap_checks <= gap_checks + 1;
            end
            gap       <= 1;
            quiet     <= 1'b1;
            have_prev <= 1'b1;
        end
        else
        begin
            gap <= gap + 1;
            if (isa_read_req)
            begin
                quiet <= 1'b0;
            end
        end
    end

    a_reset_quiet: assert property (
        @(posedge clk)
        rst_check |-> (!ins_valid && !isa_read_req && !ddr_rd_en && !halted && load_times == '0)
    ) else
    begin
        err_reset++;
        $write("Error at %0t: ins_valid/isa_read_req/ddr_rd_en/halted/load_times", $time);
        $display(" expected 0 got %b/%b/%b/%b/%0d",
            $sampled(ins_valid), $sampled(isa_read_req), $sampled(ddr_rd_en),
            $sampled(halted), $sampled(load_times));
    end

    a_ins_order: assert property (
        @(posedge clk) disable iff (!rst)
        ins_valid |-> (ins_idx < PROGRAM_WORDS && ins_word == exp_word)
    ) else
    begin
        err_order++;
        $display("Error at %0t: ins_word expected %h got %h (instruction %0d)",
            $time, $sampled(exp_word), $sampled(ins_word), $sampled(ins_idx));
    end

    a_rd_addr_range: assert property (
        @(posedge clk) disable iff (!rst)
        ddr_rd_en |-> (ddr_rd_addr % WORD_BYTES == 0 && ddr_rd_addr / WORD_BYTES < PROGRAM_WORDS)
    ) else
    begin
        err_addr++;
        $display("Error at %0t: ddr_rd_addr expected 8*k with k < %0d got %h",
            $time, PROGRAM_WORDS, $sampled(ddr_rd_addr));
    end

    a_rd_addr_step: assert property (
        @(posedge clk) disable iff (!rst)
        (ddr_rd_en && rd_seen) |-> (ddr_rd_addr == prev_rd_addr + WORD_BYTES)
    ) else
    begin
        err_addr++;
        $display("Error at %0t: ddr_rd_addr expected %h got %h", $time,
            ddr_addr_t'($sampled(prev_rd_addr) + WORD_BYTES), $sampled(ddr_rd_addr));
    end

    // Hits inside one window come every other cycle.
    a_hit_spacing: assert property (
        @(posedge clk) disable iff (!rst)
        (ins_valid && have_prev && quiet) |-> (gap == 2)
    ) else
    begin
        err_gap++;
        $display("Error at %0t: ins_valid spacing expected 2 got %0d", $time, $sampled(gap));
    end

    a_halt_after_ret: assert property (
        @(posedge clk) disable iff (!rst)
        $rose(halted) |-> ($past(ins_valid) && $past(ins_op) == OP_RET)
    ) else
    begin
        err_halt++;
        $display("Error at %0t: halted rose without a delivered RET instruction", $time);
    end

    a_idle_after_halt: assert property (
        @(posedge clk) disable iff (!rst)
        halted |-> (!ins_valid && !isa_read_req)
    ) else
    begin
        err_halt++;
        $display("Error at %0t: ins_valid/isa_read_req after halt expected 0/0 got %b/%b",
            $time, $sampled(ins_valid), $sampled(isa_read_req));
    end

    // Random program with a single RET as the last word.
    task automatic build_program();
        opcode_t   ops [10];
        ins_word_t w;
        ops = '{OP_RESET, OP_LOADRBR, OP_LOADCBC, OP_STORERBR, OP_STORECBC,
                OP_COPY, OP_ADD, OP_SUB, OP_TSC, OP_ABS};
        for (int i = 0; i < PROGRAM_WORDS; i++)
        begin
            w.opcode   = ops[$urandom % 10];
            w.cam_addr = cam_addr_t'($urandom);
            w.oprand   = oprand_t'($urandom);
            w.mem_addr = mem_addr_t'($urandom);
            prog[i]    = w;
        end
        prog[PROGRAM_WORDS-1].opcode = OP_RET;
    endtask

    task automatic wait_for_halt(output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < HALT_TIMEOUT)
        begin
            @(posedge clk);
            #DRIVE_DLY;
            cycles++;
            seen = halted;
        end
    endtask

    task automatic close_test(input string name, input int errors);
        if (errors == 0)
        begin
            tests_passed++;
            $display("Test %s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("Test %s: %0d errors", name, errors);
        end
    endtask

    initial
    begin
        bit done;
        int loads_exp;
        rst       = 1'b0;
        rst_check = 1'b1;
        void'($urandom(RAND_SEED));
        build_program();
        repeat (4) @(posedge clk);
        #DRIVE_DLY rst = 1'b1;
        @(posedge clk);
        #DRIVE_DLY rst_check = 1'b0;
        close_test("reset state", err_reset);

        wait_for_halt(done);
        if (!done)
        begin
            $display("Timeout: halted did not rise within %0d cycles", HALT_TIMEOUT);
            tests_failed++;
        end
        else
        begin
            assert (ins_idx == PROGRAM_WORDS) else
            begin
                err_order++;
                $display("Error at %0t: instruction count expected %0d got %0d",
                    $time, PROGRAM_WORDS, ins_idx);
            end
            close_test("instruction order", err_order);

            // Fills never overlap, so each word is read exactly once.
            assert (rd_count == PROGRAM_WORDS) else
            begin
                err_addr++;
                $display("Error at %0t: DDR read count expected %0d got %0d",
                    $time, PROGRAM_WORDS, rd_count);
            end
            close_test("DDR addressing", err_addr);

            assert (gap_checks > 0) else
            begin
                err_gap++;
                $display("No two deliveries were seen inside one cache window");
            end
            close_test("hit throughput", err_gap);

            loads_exp = (PROGRAM_WORDS + ISA_DEPTH - 1) / ISA_DEPTH;
            assert (load_times == loads_exp) else
            begin
                err_loads++;
                $display("Error at %0t: load_times expected %0d got %0d",
                    $time, loads_exp, load_times);
            end
            close_test("refill count", err_loads);

            repeat (QUIET_CYCLES) @(posedge clk);
            #DRIVE_DLY;
            close_test("halt", err_halt);
        end

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0)
        begin
            $display("TB PASSED");
        end
        else
        begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/ddr_model.sv ====
module ddr_model
    import ap_isa_pkg::*;
    import ap_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rd_en,
    input  ddr_addr_t rd_addr,
    input  ins_word_t image [PROGRAM_WORDS],
    output logic      rd_valid,
    output ins_word_t rd_data
);

    localparam int DRIVE_DLY = 1;

    // Read pipeline, stage 0 holds the read taken at the latest edge.
    logic      vld_pipe [DDR_LATENCY];
    ins_word_t dat_pipe [DDR_LATENCY];

    // Word lookup in the program image, zero outside the program.
    function automatic ins_word_t read_image(ddr_addr_t addr);
        ddr_addr_t idx;
        idx = addr / DDR_BYTES_PER_WORD;
        if (idx < PROGRAM_WORDS)
        begin
            return image[idx];
        end
        return '0;
    endfunction

    initial
    begin
        rd_valid = 1'b0;
        rd_data  = '0;
        for (int i = 0; i < DDR_LATENCY; i++)
        begin
            vld_pipe[i] = 1'b0;
            dat_pipe[i] = '0;
        end
        forever
        begin
            @(posedge clk);
            for (int i = DDR_LATENCY - 1; i > 0; i--)
            begin
                vld_pipe[i] = vld_pipe[i-1];
                dat_pipe[i] = dat_pipe[i-1];
            end
            vld_pipe[0] = rd_en;
            dat_pipe[0] = rd_en ? read_image(rd_addr) : '0;
            #DRIVE_DLY;
            rd_valid = vld_pipe[DDR_LATENCY-1];
            rd_data  = dat_pipe[DDR_LATENCY-1];
        end
    end

endmodule

// ==== source/ap_fetch_top.sv ====
module ap_fetch_top
    import ap_isa_pkg::*;
    import ap_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      ddr_rd_valid,
    input  ins_word_t ddr_rd_data,
    output logic      ddr_rd_en,
    output ddr_addr_t ddr_rd_addr,
    output ins_word_t ins_word,
    output logic      ins_valid,
    output logic      halted,
    output load_cnt_t load_times,
    output logic      isa_read_req
);

    mem_addr_t fetch_addr;
    fill_req_t fill_req;
    logic      beat_valid;
    ins_word_t beat_data;
    load_cnt_t rd_cnt;

    program_counter u_pc (
        .clk        (clk),
        .rst        (rst),
        .ins_valid  (ins_valid),
        .ins_word   (ins_word),
        .fetch_addr (fetch_addr),
        .halted     (halted)
    );

    ins_cache u_cache (
        .clk          (clk),
        .rst          (rst),
        .fetch_addr   (fetch_addr),
        .beat_valid   (beat_valid),
        .beat_data    (beat_data),
        .rd_cnt       (rd_cnt),
        .ins_word     (ins_word),
        .ins_valid    (ins_valid),
        .isa_read_req (isa_read_req),
        .fill_req     (fill_req),
        .load_times   (load_times)
    );

    // Refills go out to DDR through the burst reader.
    isa_burst_reader u_reader (
        .clk          (clk),
        .rst          (rst),
        .isa_read_req (isa_read_req),
        .fill_req     (fill_req),
        .ddr_rd_valid (ddr_rd_valid),
        .ddr_rd_data  (ddr_rd_data),
        .ddr_rd_en    (ddr_rd_en),
        .ddr_rd_addr  (ddr_rd_addr),
        .beat_valid   (beat_valid),
        .beat_data    (beat_data),
        .rd_cnt       (rd_cnt)
    );

endmodule

// ==== source/ap_isa_pkg.sv ====
package ap_isa_pkg;

    // Operation code of one instruction.
    typedef logic [3:0] opcode_t;

    localparam opcode_t OP_RESET    = 4'd1;
    localparam opcode_t OP_RET      = 4'd2;
    localparam opcode_t OP_LOADRBR  = 4'd4;
    localparam opcode_t OP_LOADCBC  = 4'd5;
    localparam opcode_t OP_STORERBR = 4'd6;
    localparam opcode_t OP_STORECBC = 4'd7;
    localparam opcode_t OP_COPY     = 4'd8;
    localparam opcode_t OP_ADD      = 4'd9;
    localparam opcode_t OP_SUB      = 4'd10;
    localparam opcode_t OP_TSC      = 4'd11;
    localparam opcode_t OP_ABS      = 4'd12;

    // Row address into the CAM array.
    typedef logic [7:0] cam_addr_t;

    // Selector for the second operand.
    typedef logic [1:0] oprand_t;

    // Instruction memory address, also the program counter value and cache tag.
    typedef logic [15:0] mem_addr_t;

    // One instruction word, 30 bits, opcode in the top bits.
    typedef struct packed {
        opcode_t   opcode;
        cam_addr_t cam_addr;
        oprand_t   oprand;
        mem_addr_t mem_addr;
    } ins_word_t;

    // Cache window and program size in instruction words.
    localparam int ISA_DEPTH     = 16;
    localparam int PROGRAM_WORDS = 40;
    localparam int ISA_IDX_W     = $clog2(ISA_DEPTH);

    // Index into the cache window.
    typedef logic [ISA_IDX_W-1:0] isa_idx_t;

    // Fill counter and beat count.
    typedef logic [9:0] load_cnt_t;

endpackage

// ==== source/ap_mem_pkg.sv ====
package ap_mem_pkg;

    import ap_isa_pkg::*;

    // Byte address on the DDR side.
    typedef logic [27:0] ddr_addr_t;

    // Each instruction sits in one 64-bit DDR word.
    localparam ddr_addr_t DDR_BYTES_PER_WORD = 28'd8;

    // Read latency of the DDR port in cycles.
    localparam int DDR_LATENCY = 2;

    // One refill of the cache window.
    typedef struct packed {
        ddr_addr_t addr;
        load_cnt_t len;
    } fill_req_t;

endpackage

// ==== source/ins_cache.sv ====
module ins_cache
    import ap_isa_pkg::*;
    import ap_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  mem_addr_t fetch_addr,
    input  logic      beat_valid,
    input  ins_word_t beat_data,
    input  load_cnt_t rd_cnt,
    output ins_word_t ins_word,
    output logic      ins_valid,
    output logic      isa_read_req,
    output fill_req_t fill_req,
    output load_cnt_t load_times
);

    typedef enum logic [1:0] {
        IDLE,
        SERVE,
        FILL
    } cache_state_t;

    cache_state_t state;

    // Window start address and whether a window has been loaded yet.
    mem_addr_t    tag;
    logic         tag_valid;

    // Set once a RET has gone out. Fetch is over after that.
    logic         ret_done;

    ins_word_t    mem [ISA_DEPTH];

    mem_addr_t    offset;
    mem_addr_t    remain;
    load_cnt_t    fill_len;
    load_cnt_t    wr_cnt;
    isa_idx_t     rd_idx;
    isa_idx_t     wr_idx;
    logic         hit;
    logic         last_beat;
    logic         ret_out;

    // Offset of the requested address inside the current window.
    assign offset = fetch_addr - tag;
    assign hit    = tag_valid && (offset < ISA_DEPTH);
    assign rd_idx = offset[ISA_IDX_W-1:0];

    // Words left in the program from the missing address.
    assign remain   = mem_addr_t'(PROGRAM_WORDS) - fetch_addr;
    assign fill_len = (remain < ISA_DEPTH) ? load_cnt_t'(remain) : load_cnt_t'(ISA_DEPTH);

    // Beats are numbered from one.
    assign wr_cnt = rd_cnt - 1'b1;
    assign wr_idx = wr_cnt[ISA_IDX_W-1:0];

    assign last_beat = beat_valid && (rd_cnt == fill_req.len);
    assign ret_out   = ins_valid && (ins_word.opcode == OP_RET);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state        <= IDLE;
            tag          <= '0;
            tag_valid    <= 1'b0;
            ret_done     <= 1'b0;
            ins_valid    <= 1'b0;
            isa_read_req <= 1'b0;
            fill_req     <= '0;
            load_times   <= '0;
        end
        else
        begin
            ins_valid <= 1'b0;
            if (ret_out)
            begin
                ret_done <= 1'b1;
            end
            case (state)
                IDLE:
                begin
                    // Hold here for good once the RET has been delivered.
                    if (!ret_done && !ret_out)
                    begin
                        state <= SERVE;
                    end
                end
                SERVE:
                begin
                    if (hit)
                    begin
                        ins_valid <= 1'b1;
                        state     <= IDLE;
                    end
                    else
                    begin
                        // On a miss the new window starts at the missing address.
                        tag           <= fetch_addr;
                        tag_valid     <= 1'b1;
                        fill_req.addr <= ddr_addr_t'(fetch_addr) * DDR_BYTES_PER_WORD;
                        fill_req.len  <= fill_len;
                        isa_read_req  <= 1'b1;
                        state         <= FILL;
                    end
                end
                FILL:
                begin
                    if (last_beat)
                    begin
                        isa_read_req <= 1'b0;
                        load_times   <= load_times + 1'b1;
                        state        <= IDLE;
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Instruction read out on a hit.
    always_ff @(posedge clk)
    begin
        if (state == SERVE && hit)
        begin
            ins_word <= mem[rd_idx];
        end
    end

    // Beats from the burst reader land in the window array.
    always_ff @(posedge clk)
    begin
        if (state == FILL && beat_valid)
        begin
            mem[wr_idx] <= beat_data;
        end
    end

    // Nothing is delivered while refill beats are still arriving.
    a_no_valid_in_fill: assert property (
        @(posedge clk) disable iff (!rst)
        beat_valid |-> !$rose(ins_valid)
    ) else $error("ins_valid rose during a fill");

    // Beat numbers from the reader must stay inside the window.
    a_wr_idx_range: assert property (
        @(posedge clk) disable iff (!rst)
        (state == FILL && beat_valid) |-> (rd_cnt != '0 && wr_cnt < ISA_DEPTH)
    ) else $error("fill write index %0d out of range", wr_cnt);

endmodule

// ==== source/isa_burst_reader.sv ====
module isa_burst_reader
    import ap_isa_pkg::*;
    import ap_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      isa_read_req,
    input  fill_req_t fill_req,
    input  logic      ddr_rd_valid,
    input  ins_word_t ddr_rd_data,
    output logic      ddr_rd_en,
    output ddr_addr_t ddr_rd_addr,
    output logic      beat_valid,
    output ins_word_t beat_data,
    output load_cnt_t rd_cnt
);

    // Number of reads already sent to DDR for this request.
    load_cnt_t iss_cnt;
    logic      issue;

    assign issue = isa_read_req && (iss_cnt < fill_req.len);

    // Issue side, one single-word read per cycle.
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            iss_cnt   <= '0;
            ddr_rd_en <= 1'b0;
        end
        else if (!isa_read_req)
        begin
            iss_cnt   <= '0;
            ddr_rd_en <= 1'b0;
        end
        else
        begin
            ddr_rd_en <= issue;
            if (issue)
            begin
                iss_cnt <= iss_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            ddr_rd_addr <= fill_req.addr + ddr_addr_t'(iss_cnt) * DDR_BYTES_PER_WORD;
        end
    end

    // Return side, rd_cnt counts the beats back in arrival order.
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            rd_cnt     <= '0;
            beat_valid <= 1'b0;
        end
        else if (!isa_read_req)
        begin
            rd_cnt     <= '0;
            beat_valid <= 1'b0;
        end
        else
        begin
            beat_valid <= ddr_rd_valid;
            if (ddr_rd_valid)
            begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (ddr_rd_valid)
        begin
            beat_data <= ddr_rd_data;
        end
    end

    a_rd_cnt_le_len: assert property (
        @(posedge clk) disable iff (!rst)
        isa_read_req |-> (rd_cnt <= fill_req.len)
    ) else $error("rd_cnt %0d beyond request length %0d", rd_cnt, fill_req.len);

    a_no_read_when_idle: assert property (
        @(posedge clk) disable iff (!rst)
        !isa_read_req |-> !ddr_rd_en
    ) else $error("DDR read issued without a fill request");

    // The DDR side answers each read after a fixed latency.
    a_beat_latency: assert property (
        @(posedge clk) disable iff (!rst)
        ddr_rd_en |-> ##DDR_LATENCY ddr_rd_valid
    ) else $error("DDR beat missing %0d cycles after read", DDR_LATENCY);

endmodule

// ==== source/program_counter.sv ====
module program_counter
    import ap_isa_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      ins_valid,
    input  ins_word_t ins_word,
    output mem_addr_t fetch_addr,
    output logic      halted
);

    logic is_ret;

    assign is_ret = (ins_word.opcode == OP_RET);

    // Step to the next word on every delivered instruction until RET.
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            fetch_addr <= '0;
            halted     <= 1'b0;
        end
        else if (ins_valid && !halted)
        begin
            if (is_ret)
            begin
                halted <= 1'b1;
            end
            else
            begin
                fetch_addr <= fetch_addr + 1'b1;
            end
        end
    end

    // The program ends in RET, so fetch never runs past it.
    a_addr_in_program: assert property (
        @(posedge clk) disable iff (!rst)
        fetch_addr < PROGRAM_WORDS
    ) else $error("fetch_addr %0d past end of program", fetch_addr);

    // Once halted the cache must not deliver anything more.
    a_quiet_after_halt: assert property (
        @(posedge clk) disable iff (!rst)
        halted |-> !ins_valid
    ) else $error("instruction delivered after halt");

endmodule
